/* logic/rdm_params.svh */
`ifndef RDM_PARAMS_SVH
`define RDM_PARAMS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

// Address and data width of the AXI read port
`define RDM_ADDR_W 32
`define RDM_DATA_W 32

// Bytes carried by one data beat
`define RDM_DW_BYTES 4

// Width of the transfer size field in bytes
`define RDM_XFER_W 20

////////////////////////////////////////////////////////////
// Burst and flow limits
////////////////////////////////////////////////////////////

// Smaller of 256 beats and a 4 KB page worth of beats
`define RDM_BURST_BEATS 256
// Bytes per full burst and also the start address alignment
`define RDM_BURST_BYTES 1024

// Bursts allowed in flight at once
`define RDM_MAX_OUTSTANDING 4
// Buffer entries for four full bursts, power of two
`define RDM_BUF_DEPTH 1024

`endif

/* logic/rdm_pkg.sv */
`include "rdm_params.svh"

package rdm_pkg;

  ////////////////////////////////////////////////////////////
  // Bus payload types
  ////////////////////////////////////////////////////////////

  typedef logic [`RDM_ADDR_W-1:0] addr_t;
  typedef logic [`RDM_DATA_W-1:0] data_t;
  typedef logic [`RDM_XFER_W-1:0] xfer_t;

  ////////////////////////////////////////////////////////////
  // Counter types
  ////////////////////////////////////////////////////////////

  // Total beats minus one
  typedef logic [`RDM_XFER_W-$clog2(`RDM_DW_BYTES)-1:0] beat_cnt_t;
  // Bursts minus one, upper bits of the beat count
  typedef logic [`RDM_XFER_W-$clog2(`RDM_DW_BYTES)-$clog2(`RDM_BURST_BEATS)-1:0] burst_cnt_t;
  // AXI burst length minus one
  typedef logic [7:0] arlen_t;
  // Free outstanding slots, 0 up to the limit
  typedef logic [$clog2(`RDM_MAX_OUTSTANDING+1)-1:0] credit_t;

  // Address issuer FSM
  typedef enum logic [1:0] {
    AR_IDLE,
    AR_SEND,
    AR_STALL
  } ar_state_t;

endpackage

/* logic/rdm_cmd_setup.sv */
`include "rdm_params.svh"

module rdm_cmd_setup (
  input  logic                aclk,
  input  logic                areset,
  input  logic                ctrl_start,
  input  rdm_pkg::addr_t      ctrl_addr,
  input  rdm_pkg::xfer_t      ctrl_xfer_size,
  output logic                cmd_go,
  output rdm_pkg::addr_t      cmd_base,
  output rdm_pkg::burst_cnt_t cmd_bursts,
  output rdm_pkg::arlen_t     cmd_last_len
);

  // Byte offset bits inside a beat
  localparam int LOG_DW = $clog2(`RDM_DW_BYTES);
  // Beat index bits inside a burst
  localparam int LOG_BURST = $clog2(`RDM_BURST_BEATS);
  localparam int BEAT_W = $bits(rdm_pkg::beat_cnt_t);
  localparam rdm_pkg::addr_t ALIGN_MASK = rdm_pkg::addr_t'(`RDM_BURST_BYTES - 1);

  logic               start_d1;
  rdm_pkg::beat_cnt_t total_r;
  rdm_pkg::beat_cnt_t size_beats;
  logic               size_partial;

  ////////////////////////////////////////////////////////////
  // Stage 1 capture of the command
  ////////////////////////////////////////////////////////////

  // Whole beats in the size and a flag for a leftover partial beat
  assign size_beats   = ctrl_xfer_size[`RDM_XFER_W-1:LOG_DW];
  assign size_partial = |ctrl_xfer_size[LOG_DW-1:0];

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up to whole beats then keep as count minus one
      total_r  <= size_partial ? size_beats : size_beats - 1'b1;
      // Start on a burst boundary
      cmd_base <= ctrl_addr & ~ALIGN_MASK;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 split into bursts
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    cmd_bursts   <= total_r[BEAT_W-1:LOG_BURST];
    cmd_last_len <= total_r[LOG_BURST-1:0];
  end

  // Go pulse lines up with the split fields
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      cmd_go   <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      cmd_go   <= start_d1;
    end
  end

  // A new start must not land on a command still in setup
  a_no_start_in_setup: assert property (
    @(posedge aclk) disable iff (areset)
    ctrl_start |-> !start_d1 && !cmd_go
  );

endmodule

/* logic/rdm_ar_issue.sv */
`include "rdm_params.svh"

module rdm_ar_issue (
  input  logic                aclk,
  input  logic                areset,
  input  logic                cmd_go,
  input  rdm_pkg::addr_t      cmd_base,
  input  rdm_pkg::burst_cnt_t cmd_bursts,
  input  rdm_pkg::arlen_t     cmd_last_len,
  input  logic                burst_retired,
  output logic                m_axi_arvalid,
  input  logic                m_axi_arready,
  output rdm_pkg::addr_t      m_axi_araddr,
  output rdm_pkg::arlen_t     m_axi_arlen
);

  localparam rdm_pkg::arlen_t  FULL_LEN   = rdm_pkg::arlen_t'(`RDM_BURST_BEATS - 1);
  localparam rdm_pkg::addr_t   ADDR_STEP  = rdm_pkg::addr_t'(`RDM_BURST_BYTES);
  localparam rdm_pkg::credit_t CREDIT_MAX = rdm_pkg::credit_t'(`RDM_MAX_OUTSTANDING);

  rdm_pkg::ar_state_t  state;
  rdm_pkg::addr_t      addr_r;
  rdm_pkg::burst_cnt_t bursts_left;
  rdm_pkg::arlen_t     last_len_r;
  rdm_pkg::credit_t    credit;
  logic                ar_xfer;
  logic                final_burst;
  logic                have_credit;
  logic                cmd_load;

  assign ar_xfer     = m_axi_arvalid & m_axi_arready;
  assign final_burst = bursts_left == '0;
  assign have_credit = credit != '0;
  // New commands only land while idle
  assign cmd_load    = cmd_go && (state == rdm_pkg::AR_IDLE);

  ////////////////////////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= rdm_pkg::AR_IDLE;
    end else begin
      case (state)
        rdm_pkg::AR_IDLE: begin
          if (cmd_go) begin
            state <= have_credit ? rdm_pkg::AR_SEND : rdm_pkg::AR_STALL;
          end
        end
        rdm_pkg::AR_SEND: begin
          // Always drop valid for a cycle after a handshake
          if (m_axi_arready) begin
            state <= final_burst ? rdm_pkg::AR_IDLE : rdm_pkg::AR_STALL;
          end
        end
        rdm_pkg::AR_STALL: begin
          if (have_credit) begin
            state <= rdm_pkg::AR_SEND;
          end
        end
        default: state <= rdm_pkg::AR_IDLE;
      endcase
    end
  end

  assign m_axi_arvalid = state == rdm_pkg::AR_SEND;

  ////////////////////////////////////////////////////////////
  // Address and burst count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (cmd_load) begin
      bursts_left <= cmd_bursts;
    end else if (ar_xfer && !final_burst) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_load) begin
      addr_r     <= cmd_base;
      last_len_r <= cmd_last_len;
    end else if (ar_xfer) begin
      addr_r <= addr_r + ADDR_STEP;
    end
  end

  assign m_axi_araddr = addr_r;
  // Only the final burst may be short
  assign m_axi_arlen  = final_burst ? last_len_r : FULL_LEN;

  ////////////////////////////////////////////////////////////
  // Outstanding credits
  ////////////////////////////////////////////////////////////

  // One credit per burst from AR handshake until its last beat leaves the stream
  always_ff @(posedge aclk) begin
    if (areset) begin
      credit <= CREDIT_MAX;
    end else if (ar_xfer && !burst_retired) begin
      credit <= credit - 1'b1;
    end else if (!ar_xfer && burst_retired) begin
      credit <= credit + 1'b1;
    end
  end

  a_ar_stable: assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen)
  );

  // Retire pulses from the buffer never outrun issued bursts
  a_credit_bound: assert property (
    @(posedge aclk) disable iff (areset)
    credit <= CREDIT_MAX
  );

endmodule

/* logic/rdm_r_buffer.sv */
`include "rdm_params.svh"

module rdm_r_buffer (
  input  logic           aclk,
  input  logic           areset,
  input  logic           m_axi_rvalid,
  output logic           m_axi_rready,
  input  rdm_pkg::data_t m_axi_rdata,
  input  logic           m_axi_rlast,
  output logic           m_axis_tvalid,
  input  logic           m_axis_tready,
  output rdm_pkg::data_t m_axis_tdata,
  output logic           m_axis_tlast,
  output logic           burst_retired
);

  localparam int AW = $clog2(`RDM_BUF_DEPTH);

  // Each entry holds last flag above the data word
  logic [`RDM_DATA_W:0] mem [`RDM_BUF_DEPTH];
  // Pointers carry one wrap bit above the index
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        mem_empty;
  logic        mem_full;
  logic        out_pop;
  logic        out_load;
  logic        mem_rd;
  logic        mem_wr;
  logic        bypass;

  // Credit limit keeps the buffer from ever filling
  assign m_axi_rready = 1'b1;

  assign mem_empty = wr_ptr == rd_ptr;
  assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  ////////////////////////////////////////////////////////////
  // Output stage control
  ////////////////////////////////////////////////////////////

  assign out_pop  = m_axis_tvalid & m_axis_tready;
  // Output register free this cycle
  assign out_load = !m_axis_tvalid || out_pop;
  assign mem_rd   = out_load && !mem_empty;
  // Empty memory lets an R beat go straight to the output register
  assign bypass   = out_load && mem_empty && m_axi_rvalid;
  assign mem_wr   = m_axi_rvalid && !bypass;

  assign burst_retired = out_pop & m_axis_tlast;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr[AW-1:0]] <= {m_axi_rlast, m_axi_rdata};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (mem_wr) wr_ptr <= wr_ptr + 1'b1;
      if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Registered read into the output stage
  always_ff @(posedge aclk) begin
    if (mem_rd) begin
      {m_axis_tlast, m_axis_tdata} <= mem[rd_ptr[AW-1:0]];
    end else if (bypass) begin
      {m_axis_tlast, m_axis_tdata} <= {m_axi_rlast, m_axi_rdata};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axis_tvalid <= 1'b0;
    end else if (out_load) begin
      m_axis_tvalid <= mem_rd || bypass;
    end
  end

  a_no_overflow: assert property (
    @(posedge aclk) disable iff (areset)
    mem_wr |-> !mem_full
  );

  a_axis_stable: assert property (
    @(posedge aclk) disable iff (areset)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)
  );

endmodule

/* logic/rdm_r_tracker.sv */
module rdm_r_tracker (
  input  logic                aclk,
  input  logic                areset,
  input  logic                cmd_go,
  input  rdm_pkg::burst_cnt_t cmd_bursts,
  input  logic                m_axi_rvalid,
  input  logic                m_axi_rlast,
  output logic                ctrl_done
);

  logic                busy;
  rdm_pkg::burst_cnt_t bursts_left;
  logic                rlast_beat;
  logic                final_beat;

  // rready is tied high so rvalid alone is a transfer
  assign rlast_beat = m_axi_rvalid & m_axi_rlast;
  assign final_beat = rlast_beat && busy && (bursts_left == '0);

  ////////////////////////////////////////////////////////////
  // Burst countdown
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      busy        <= 1'b0;
      bursts_left <= '0;
    end else if (cmd_go) begin
      busy        <= 1'b1;
      bursts_left <= cmd_bursts;
    end else if (rlast_beat && busy) begin
      if (bursts_left == '0) begin
        busy <= 1'b0;
      end else begin
        bursts_left <= bursts_left - 1'b1;
      end
    end
  end

  // Done follows the final rlast by one cycle
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= final_beat;
    end
  end

  // Slave returns no burst that was never requested
  a_rlast_when_busy: assert property (
    @(posedge aclk) disable iff (areset)
    rlast_beat |-> busy
  );

endmodule

/* logic/rdm_read_master.sv */
module rdm_read_master (
  input  logic           aclk,
  input  logic           areset,

  // Command
  input  logic           ctrl_start,
  input  rdm_pkg::addr_t ctrl_addr,
  input  rdm_pkg::xfer_t ctrl_xfer_size,
  output logic           ctrl_done,

  // AXI read address
  output logic            m_axi_arvalid,
  input  logic            m_axi_arready,
  output rdm_pkg::addr_t  m_axi_araddr,
  output rdm_pkg::arlen_t m_axi_arlen,

  // AXI read data
  input  logic           m_axi_rvalid,
  output logic           m_axi_rready,
  input  rdm_pkg::data_t m_axi_rdata,
  input  logic           m_axi_rlast,

  // Stream out
  output logic           m_axis_tvalid,
  input  logic           m_axis_tready,
  output rdm_pkg::data_t m_axis_tdata,
  output logic           m_axis_tlast
);

  logic                cmd_go;
  rdm_pkg::addr_t      cmd_base;
  rdm_pkg::burst_cnt_t cmd_bursts;
  rdm_pkg::arlen_t     cmd_last_len;
  logic                burst_retired;

  ////////////////////////////////////////////////////////////
  // Command setup then address issue
  ////////////////////////////////////////////////////////////

  rdm_cmd_setup rdm_cmd_setup_inst (
    .aclk           (aclk),
    .areset         (areset),
    .ctrl_start     (ctrl_start),
    .ctrl_addr      (ctrl_addr),
    .ctrl_xfer_size (ctrl_xfer_size),
    .cmd_go         (cmd_go),
    .cmd_base       (cmd_base),
    .cmd_bursts     (cmd_bursts),
    .cmd_last_len   (cmd_last_len)
  );

  rdm_ar_issue rdm_ar_issue_inst (
    .aclk          (aclk),
    .areset        (areset),
    .cmd_go        (cmd_go),
    .cmd_base      (cmd_base),
    .cmd_bursts    (cmd_bursts),
    .cmd_last_len  (cmd_last_len),
    .burst_retired (burst_retired),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  ////////////////////////////////////////////////////////////
  // Read data path and completion
  ////////////////////////////////////////////////////////////

  rdm_r_buffer rdm_r_buffer_inst (
    .aclk          (aclk),
    .areset        (areset),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_retired (burst_retired)
  );

  rdm_r_tracker rdm_r_tracker_inst (
    .aclk         (aclk),
    .areset       (areset),
    .cmd_go       (cmd_go),
    .cmd_bursts   (cmd_bursts),
    .m_axi_rvalid (m_axi_rvalid),
    .m_axi_rlast  (m_axi_rlast),
    .ctrl_done    (ctrl_done)
  );

endmodule

/* bench/rdm_tb_slave.sv */
`include "rdm_params.svh"

module rdm_tb_slave (
  input  logic            aclk,
  input  logic            areset,
  input  logic            m_axi_arvalid,
  output logic            m_axi_arready,
  input  rdm_pkg::addr_t  m_axi_araddr,
  input  rdm_pkg::arlen_t m_axi_arlen,
  output logic            m_axi_rvalid,
  input  logic            m_axi_rready,
  output rdm_pkg::data_t  m_axi_rdata,
  output logic            m_axi_rlast
);

  // Accepted bursts waiting for read data, oldest first
  rdm_pkg::addr_t  burst_addr_q[$];
  rdm_pkg::arlen_t burst_len_q[$];
  // Beat index inside the burst at the head of the queue
  int              beat_idx = 0;

  // Quiet bus before the first clock edge
  initial begin
    m_axi_arready <= 1'b0;
    m_axi_rvalid  <= 1'b0;
    m_axi_rdata   <= '0;
    m_axi_rlast   <= 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // AR accept and R return
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (areset) begin
      m_axi_arready <= 1'b0;
      m_axi_rvalid  <= 1'b0;
      m_axi_rdata   <= '0;
      m_axi_rlast   <= 1'b0;
      beat_idx = 0;
      burst_addr_q.delete();
      burst_len_q.delete();
    end else begin
      // Queue every burst on its AR handshake
      if (m_axi_arvalid && m_axi_arready) begin
        burst_addr_q.push_back(m_axi_araddr);
        burst_len_q.push_back(m_axi_arlen);
      end
      // Beat on the bus this cycle was taken
      if (m_axi_rvalid && m_axi_rready) begin
        if (m_axi_rlast) begin
          void'(burst_addr_q.pop_front());
          void'(burst_len_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      // Random AR stalls
      m_axi_arready <= $urandom_range(0, 3) != 0;
      // Random gaps between R beats, data is the beat's own byte address
      if (burst_addr_q.size() != 0 && $urandom_range(0, 3) != 0) begin
        m_axi_rvalid <= 1'b1;
        m_axi_rdata  <= burst_addr_q[0] + rdm_pkg::addr_t'(beat_idx * `RDM_DW_BYTES);
        m_axi_rlast  <= beat_idx == int'(burst_len_q[0]);
      end else begin
        m_axi_rvalid <= 1'b0;
      end
    end
  end

endmodule

/* bench/tb_rdm_read_master.sv */
`include "rdm_params.svh"

module tb_rdm_read_master;

  localparam int NUM_CMDS   = 30;
  localparam int WAIT_LIMIT = 200000;

  logic                aclk;
  logic                areset;
  logic                ctrl_start;
  rdm_pkg::addr_t      ctrl_addr;
  rdm_pkg::xfer_t      ctrl_xfer_size;
  logic                ctrl_done;
  logic                m_axi_arvalid;
  logic                m_axi_arready;
  rdm_pkg::addr_t      m_axi_araddr;
  rdm_pkg::arlen_t     m_axi_arlen;
  logic                m_axi_rvalid;
  logic                m_axi_rready;
  rdm_pkg::data_t      m_axi_rdata;
  logic                m_axi_rlast;
  logic                m_axis_tvalid;
  logic                m_axis_tready;
  rdm_pkg::data_t      m_axis_tdata;
  logic                m_axis_tlast;

  // Reference model queues, filled per command
  rdm_pkg::addr_t      exp_ar_addr_q[$];
  rdm_pkg::arlen_t     exp_ar_len_q[$];
  rdm_pkg::data_t      exp_data_q[$];
  logic                exp_last_q[$];
  int                  exp_bursts_q[$];

  // Scoreboard counters
  int   ar_count      = 0;
  int   retired_count = 0;
  int   done_count    = 0;
  int   rlast_seen    = 0;
  int   stall_left    = 0;
  logic done_due      = 1'b0;
  logic in_reset_q    = 1'b0;

  initial aclk = 1'b0;
  always #10 aclk = ~aclk;

  rdm_read_master rdm_read_master_inst (
    .aclk           (aclk),
    .areset         (areset),
    .ctrl_start     (ctrl_start),
    .ctrl_addr      (ctrl_addr),
    .ctrl_xfer_size (ctrl_xfer_size),
    .ctrl_done      (ctrl_done),
    .m_axi_arvalid  (m_axi_arvalid),
    .m_axi_arready  (m_axi_arready),
    .m_axi_araddr   (m_axi_araddr),
    .m_axi_arlen    (m_axi_arlen),
    .m_axi_rvalid   (m_axi_rvalid),
    .m_axi_rready   (m_axi_rready),
    .m_axi_rdata    (m_axi_rdata),
    .m_axi_rlast    (m_axi_rlast),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tlast   (m_axis_tlast)
  );

  rdm_tb_slave slave_inst (
    .aclk          (aclk),
    .areset        (areset),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rready  (m_axi_rready),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and model
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("[FAIL] time %0t %s expected 0x%0h actual 0x%0h",
                          $time, name, expected, actual));
    end
  endtask

  // Aligned base, beats rounded up, full bursts then one remainder burst
  task automatic predict_command(input rdm_pkg::addr_t addr, input rdm_pkg::xfer_t size);
    rdm_pkg::addr_t base;
    int             beats;
    int             bursts;
    int             len;
    base   = addr & ~rdm_pkg::addr_t'(`RDM_BURST_BYTES - 1);
    beats  = (int'(size) + `RDM_DW_BYTES - 1) / `RDM_DW_BYTES;
    bursts = (beats + `RDM_BURST_BEATS - 1) / `RDM_BURST_BEATS;
    for (int b = 0; b < bursts; b++) begin
      len = (b == bursts - 1) ? beats - b * `RDM_BURST_BEATS : `RDM_BURST_BEATS;
      exp_ar_addr_q.push_back(base + rdm_pkg::addr_t'(b * `RDM_BURST_BYTES));
      exp_ar_len_q.push_back(rdm_pkg::arlen_t'(len - 1));
      for (int i = 0; i < len; i++) begin
        exp_data_q.push_back(base +
          rdm_pkg::addr_t'((b * `RDM_BURST_BEATS + i) * `RDM_DW_BYTES));
        exp_last_q.push_back(i == len - 1);
      end
    end
    exp_bursts_q.push_back(bursts);
  endtask

  ////////////////////////////////////////////////////////////
  // Stream back-pressure with occasional long stalls
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (stall_left > 0) begin
      stall_left--;
      m_axis_tready <= 1'b0;
    end else if ($urandom_range(0, 299) == 0) begin
      // Longer than the buffer so the credit limit gets exercised
      stall_left = $urandom_range(200, 1200);
      m_axis_tready <= 1'b0;
    end else begin
      m_axis_tready <= $urandom_range(0, 3) != 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    // Idle outputs once a reset edge has passed, up to the edge after release
    if (in_reset_q) begin
      check_value("m_axi_arvalid", 0, m_axi_arvalid);
      check_value("m_axis_tvalid", 0, m_axis_tvalid);
      check_value("ctrl_done", 0, ctrl_done);
    end
    in_reset_q = areset;
    if (areset) begin
      done_due = 1'b0;
    end else begin
      check_value("m_axi_rready", 1, m_axi_rready);
      if (m_axi_arvalid && m_axi_arready) begin
        if (exp_ar_addr_q.size() == 0) begin
          abort_run("An AR handshake happened while no burst was expected");
        end
        check_value("m_axi_araddr", exp_ar_addr_q.pop_front(), m_axi_araddr);
        check_value("m_axi_arlen", exp_ar_len_q.pop_front(), m_axi_arlen);
        ar_count++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_data_q.size() == 0) begin
          abort_run("A stream beat came out while no beat was expected");
        end
        check_value("m_axis_tdata", exp_data_q.pop_front(), m_axis_tdata);
        check_value("m_axis_tlast", exp_last_q.pop_front(), m_axis_tlast);
        if (m_axis_tlast) retired_count++;
      end
      check_value("outstanding_over_limit", 0,
                  (ar_count - retired_count) > `RDM_MAX_OUTSTANDING);
      // Done is due exactly one cycle after the final rlast
      check_value("ctrl_done", done_due, ctrl_done);
      if (ctrl_done) done_count++;
      done_due = 1'b0;
      if (m_axi_rvalid && m_axi_rready && m_axi_rlast) begin
        if (exp_bursts_q.size() == 0) begin
          abort_run("An R burst ended while no command was pending");
        end
        rlast_seen++;
        if (rlast_seen == exp_bursts_q[0]) begin
          void'(exp_bursts_q.pop_front());
          rlast_seen = 0;
          done_due   = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Command sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rdm_pkg::addr_t addr;
    rdm_pkg::xfer_t size;
    int             waited;
    void'($urandom(32'hdbf140af));
    areset         <= 1'b1;
    ctrl_start     <= 1'b0;
    ctrl_addr      <= '0;
    ctrl_xfer_size <= '0;
    m_axis_tready  <= 1'b0;
    repeat (5) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    for (int c = 0; c < NUM_CMDS; c++) begin
      addr = $urandom;
      size = rdm_pkg::xfer_t'($urandom_range(1, 20000));
      predict_command(addr, size);
      @(posedge aclk);
      ctrl_start     <= 1'b1;
      ctrl_addr      <= addr;
      ctrl_xfer_size <= size;
      @(posedge aclk);
      ctrl_start <= 1'b0;
      waited = 0;
      while (!ctrl_done) begin
        @(posedge aclk);
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run($sformatf("Timed out waiting for ctrl_done of command %0d", c));
        end
      end
    end
    // Stream may still hold beats after the last done
    waited = 0;
    while (exp_data_q.size() != 0) begin
      @(posedge aclk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timed out waiting for the stream output to drain");
      end
    end
    repeat (20) @(posedge aclk);
    check_value("done_count", NUM_CMDS, done_count);
    check_value("ar_left", 0, exp_ar_addr_q.size());
    check_value("retired_count", ar_count, retired_count);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* sources.f */
+incdir+logic
logic/rdm_pkg.sv
logic/rdm_cmd_setup.sv
logic/rdm_ar_issue.sv
logic/rdm_r_buffer.sv
logic/rdm_r_tracker.sv
logic/rdm_read_master.sv
bench/rdm_tb_slave.sv
bench/tb_rdm_read_master.sv

/* Bender.yml */
package:
  name: rdm_read_master

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rdm_pkg.sv
      - logic/rdm_cmd_setup.sv
      - logic/rdm_ar_issue.sv
      - logic/rdm_r_buffer.sv
      - logic/rdm_r_tracker.sv
      - logic/rdm_read_master.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/rdm_tb_slave.sv
      - bench/tb_rdm_read_master.sv
